// ==== source/dmem_map_pkg.sv ====
`default_nettype none

package dmem_map_pkg;

  // Data and byte address width of the core
  localparam int XLEN = 32;

  // One strobe per byte lane of a data word
  localparam int STRB_W = XLEN / 8;

  // Address bit that routes an access to the scratch I/O RAM
  localparam int IO_SEL_BIT = 31;

  // Scratch I/O RAM depth in words, and its word index width
  localparam int IO_WORDS = 64;
  localparam int IO_AW = $clog2(IO_WORDS);

endpackage

`default_nettype wire

// ==== source/dcache_cfg_pkg.sv ====
`default_nettype none

package dcache_cfg_pkg;

  // Direct-mapped, one word per line
  localparam int LINES = 16;
  localparam int INDEX_W = $clog2(LINES);

  // Tag is the word address above the index
  // (byte offset bits [1:0] are not part of the word address)
  localparam int TAG_W = dmem_map_pkg::XLEN - 2 - INDEX_W;

  // Backing memory depth in words, and its word index width
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW = $clog2(MEM_WORDS);

  // Cycles from a memory read pulse to its data
  localparam int MEM_LATENCY = 4;

endpackage

`default_nettype wire

// ==== source/backing_mem.sv ====
`default_nettype none

module backing_mem (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ren,
  input  logic [dmem_map_pkg::XLEN-1:0]       raddr,
  output logic                                rvalid,
  output logic [dmem_map_pkg::XLEN-1:0]       rdata,
  input  logic                                we,
  input  logic [dmem_map_pkg::XLEN-1:0]       waddr,
  input  logic [dmem_map_pkg::XLEN-1:0]       wdata,
  input  logic [dmem_map_pkg::STRB_W-1:0]     wstrb
);
  import dmem_map_pkg::*;
  import dcache_cfg_pkg::*;

  // Starts all zero for simulation
  logic [XLEN-1:0]        mem [MEM_WORDS] = '{default: '0};

  logic [MEM_LATENCY-1:0] vld_sr;
  logic [MEM_AW-1:0]      addr_sr [MEM_LATENCY];
  logic [MEM_AW-1:0]      widx;

  assign widx = waddr[MEM_AW+1:2];

  // Byte-strobed write at the edge of the request
  always_ff @(posedge clk) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (we && wstrb[b]) begin
        mem[widx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // Latency chain with one stage per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[MEM_LATENCY-2:0], ren};
    end
  end

  always_ff @(posedge clk) begin
    addr_sr[0] <= raddr[MEM_AW+1:2];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // Word leaves the array as the last stage becomes valid
  assign rvalid = vld_sr[MEM_LATENCY-1];
  assign rdata  = mem[addr_sr[MEM_LATENCY-1]];

endmodule

`default_nettype wire

// ==== source/io_scratch_ram.sv ====
`default_nettype none

module io_scratch_ram (
  input  logic                                clk,
  input  logic                                ren,
  input  logic [dmem_map_pkg::XLEN-1:0]       raddr,
  output logic [dmem_map_pkg::XLEN-1:0]       rdata,
  input  logic                                wen,
  input  logic [dmem_map_pkg::XLEN-1:0]       waddr,
  input  logic [dmem_map_pkg::XLEN-1:0]       wdata,
  input  logic [dmem_map_pkg::STRB_W-1:0]     wstrb
);
  import dmem_map_pkg::*;

  // Zero at start, like the backing memory
  logic [XLEN-1:0]  ram [IO_WORDS] = '{default: '0};

  logic [IO_AW-1:0] ridx;
  logic [IO_AW-1:0] widx;

  // Low word address bits only, upper bits alias
  assign ridx = raddr[IO_AW+1:2];
  assign widx = waddr[IO_AW+1:2];

  always_ff @(posedge clk) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (wen && wstrb[b]) begin
        ram[widx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // Registered read, output holds until the next read
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= ram[ridx];
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
`default_nettype none

module dcache (
  input  logic                                clk,
  input  logic                                rst_n,

  // Read channel from the bridge
  input  logic                                rd_valid,
  output logic                                rd_ready,
  input  logic [dmem_map_pkg::XLEN-1:0]       rd_addr,
  output logic [dmem_map_pkg::XLEN-1:0]       rd_data,
  output logic                                rd_data_valid,

  // Write channel from the bridge
  input  logic                                wr_valid,
  output logic                                wr_ready,
  input  logic [dmem_map_pkg::XLEN-1:0]       wr_addr,
  input  logic [dmem_map_pkg::XLEN-1:0]       wr_data,
  input  logic [dmem_map_pkg::STRB_W-1:0]     wr_strb,

  // Backing memory
  output logic                                mem_ren,
  output logic [dmem_map_pkg::XLEN-1:0]       mem_raddr,
  input  logic                                mem_rvalid,
  input  logic [dmem_map_pkg::XLEN-1:0]       mem_rdata,
  output logic                                mem_we,
  output logic [dmem_map_pkg::XLEN-1:0]       mem_waddr,
  output logic [dmem_map_pkg::XLEN-1:0]       mem_wdata,
  output logic [dmem_map_pkg::STRB_W-1:0]     mem_wstrb
);
  import dmem_map_pkg::*;
  import dcache_cfg_pkg::*;

  typedef enum logic [1:0] {
    C_IDLE,
    C_LOOKUP,
    C_WAIT,
    C_RESP
  } state_t;

  state_t state;
  state_t state_next;

  logic [TAG_W-1:0]   tag_arr  [LINES];
  logic [XLEN-1:0]    data_arr [LINES];
  logic [LINES-1:0]   valid_arr;

  logic [XLEN-1:0]    req_addr;
  logic [INDEX_W-1:0] req_idx;
  logic [TAG_W-1:0]   req_tag;
  logic [INDEX_W-1:0] wr_idx;
  logic [TAG_W-1:0]   wr_tag;
  logic               rd_hit;
  logic               wr_hit;
  logic               wr_fire;
  logic               fill;

  assign req_idx = req_addr[INDEX_W+1:2];
  assign req_tag = req_addr[XLEN-1:INDEX_W+2];
  assign wr_idx  = wr_addr[INDEX_W+1:2];
  assign wr_tag  = wr_addr[XLEN-1:INDEX_W+2];

  assign rd_hit = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);
  assign wr_hit = valid_arr[wr_idx] && (tag_arr[wr_idx] == wr_tag);

  // Only one request at a time, taken while idle
  assign rd_ready = (state == C_IDLE);
  assign wr_ready = (state == C_IDLE);
  assign wr_fire  = wr_valid && wr_ready;
  assign fill     = (state == C_WAIT) && mem_rvalid;

  always_comb begin
    state_next = state;
    case (state)
      C_IDLE:   if (rd_valid) state_next = C_LOOKUP;
      C_LOOKUP: state_next = rd_hit ? C_IDLE : C_WAIT;
      C_WAIT:   if (mem_rvalid) state_next = C_RESP;
      C_RESP:   state_next = C_IDLE;
      default:  state_next = C_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= C_IDLE;
      valid_arr <= '0;
    end else begin
      state <= state_next;
      if (fill) begin
        valid_arr[req_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid && rd_ready) begin
      req_addr <= rd_addr;
    end
    if (fill) begin
      tag_arr[req_idx]  <= req_tag;
      data_arr[req_idx] <= mem_rdata;
    end else if (wr_fire && wr_hit) begin
      // Write hit merges only the strobed bytes
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) begin
          data_arr[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Hit answers from lookup, miss answers after the line is filled
  assign rd_data       = data_arr[req_idx];
  assign rd_data_valid = ((state == C_LOOKUP) && rd_hit) || (state == C_RESP);

  // Single read pulse per miss, word aligned
  assign mem_ren   = (state == C_LOOKUP) && !rd_hit;
  assign mem_raddr = {req_addr[XLEN-1:2], 2'b00};

  // Write-through, no allocate on a write miss
  assign mem_we    = wr_fire;
  assign mem_waddr = wr_addr;
  assign mem_wdata = wr_data;
  assign mem_wstrb = wr_strb;

endmodule

`default_nettype wire

// ==== source/dmem_cache_bridge.sv ====
`default_nettype none

module dmem_cache_bridge (
  input  logic                                clk,
  input  logic                                rst_n,

  // Core load/store strobes
  input  logic                                dmem_ren,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_raddr,
  output logic [dmem_map_pkg::XLEN-1:0]       dmem_rdata,
  input  logic                                dmem_we,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_waddr,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_wdata,
  input  logic [dmem_map_pkg::STRB_W-1:0]     dmem_wstrb,
  output logic                                dmem_stall,

  // Cache request channels
  output logic                                cache_rd_valid,
  input  logic                                cache_rd_ready,
  output logic [dmem_map_pkg::XLEN-1:0]       cache_rd_addr,
  input  logic [dmem_map_pkg::XLEN-1:0]       cache_rd_data,
  input  logic                                cache_rd_data_valid,
  output logic                                cache_wr_valid,
  input  logic                                cache_wr_ready,
  output logic [dmem_map_pkg::XLEN-1:0]       cache_wr_addr,
  output logic [dmem_map_pkg::XLEN-1:0]       cache_wr_data,
  output logic [dmem_map_pkg::STRB_W-1:0]     cache_wr_strb,

  // Scratch I/O RAM with block-RAM timing
  output logic                                io_ren,
  output logic [dmem_map_pkg::XLEN-1:0]       io_raddr,
  input  logic [dmem_map_pkg::XLEN-1:0]       io_rdata,
  output logic                                io_wen,
  output logic [dmem_map_pkg::XLEN-1:0]       io_waddr,
  output logic [dmem_map_pkg::XLEN-1:0]       io_wdata,
  output logic [dmem_map_pkg::STRB_W-1:0]     io_wstrb
);
  import dmem_map_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_t;

  state_t state;
  state_t state_next;

  logic              io_sel_rd;
  logic              io_sel_wr;
  logic              io_sel_rd_q;
  logic              completing;
  logic              rd_accepted;
  logic              rd_done;
  logic              wr_done;
  logic              start_rd;
  logic              start_wr;
  logic [XLEN-1:0]   rd_addr_q;
  logic [XLEN-1:0]   rd_data_q;
  logic [XLEN-1:0]   wr_addr_q;
  logic [XLEN-1:0]   wr_data_q;
  logic [STRB_W-1:0] wr_strb_q;

  // Upper address bit picks I/O over the cache
  assign io_sel_rd = dmem_raddr[IO_SEL_BIT];
  assign io_sel_wr = dmem_waddr[IO_SEL_BIT];

  // Data only counts once the cache has taken our request
  assign rd_done = (state == ST_READ) && rd_accepted && cache_rd_data_valid;
  assign wr_done = (state == ST_WRITE) && cache_wr_ready;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        // Cooldown cycle lets the core advance before the next cache request
        if (!completing) begin
          if (dmem_ren && !io_sel_rd) begin
            state_next = ST_READ;
          end else if (dmem_we && !io_sel_wr) begin
            state_next = ST_WRITE;
          end
        end
      end
      ST_READ: begin
        if (rd_done) begin
          state_next = ST_IDLE;
        end
      end
      ST_WRITE: begin
        if (wr_done) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  assign start_rd = (state == ST_IDLE) && (state_next == ST_READ);
  assign start_wr = (state == ST_IDLE) && (state_next == ST_WRITE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      completing  <= 1'b0;
      rd_accepted <= 1'b0;
      io_sel_rd_q <= 1'b0;
    end else begin
      state      <= state_next;
      completing <= rd_done || wr_done;
      // Track the read handshake so a stray data pulse is ignored
      if (rd_done) begin
        rd_accepted <= 1'b0;
      end else if (cache_rd_valid && cache_rd_ready) begin
        rd_accepted <= 1'b1;
      end
      // Remember the source of the last accepted read for the data mux
      if (io_ren || start_rd) begin
        io_sel_rd_q <= io_ren;
      end
    end
  end

  // Request registered as the FSM leaves idle
  always_ff @(posedge clk) begin
    if (start_rd) begin
      rd_addr_q <= dmem_raddr;
    end
    if (start_wr) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
    // Keep the loaded word until the next cached read completes
    if (rd_done) begin
      rd_data_q <= cache_rd_data;
    end
  end

  // Valid held through back-pressure, dropped as the data arrives
  assign cache_rd_valid = (state == ST_READ) && !rd_done;
  assign cache_rd_addr  = rd_addr_q;

  assign cache_wr_valid = (state == ST_WRITE);
  assign cache_wr_addr  = wr_addr_q;
  assign cache_wr_data  = wr_data_q;
  assign cache_wr_strb  = wr_strb_q;

  // I/O passes straight through whenever no cache access is in flight
  assign io_ren   = (state == ST_IDLE) && dmem_ren && io_sel_rd;
  assign io_raddr = dmem_raddr;
  assign io_wen   = (state == ST_IDLE) && dmem_we && io_sel_wr;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  // Fresh cache word on the completion cycle, registered copy after it
  assign dmem_rdata = io_sel_rd_q ? io_rdata : (rd_done ? cache_rd_data : rd_data_q);

  // Stall from next state, plus cooldown unless the core is doing I/O
  assign dmem_stall = (state_next != ST_IDLE) || (completing && !(io_ren || io_wen));

endmodule

`default_nettype wire

// ==== source/dmem_subsystem.sv ====
`default_nettype none

module dmem_subsystem (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                dmem_ren,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_raddr,
  output logic [dmem_map_pkg::XLEN-1:0]       dmem_rdata,
  input  logic                                dmem_we,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_waddr,
  input  logic [dmem_map_pkg::XLEN-1:0]       dmem_wdata,
  input  logic [dmem_map_pkg::STRB_W-1:0]     dmem_wstrb,
  output logic                                dmem_stall
);
  import dmem_map_pkg::*;

  // Bridge to cache
  logic              cache_rd_valid;
  logic              cache_rd_ready;
  logic              cache_rd_data_valid;
  logic              cache_wr_valid;
  logic              cache_wr_ready;
  logic [XLEN-1:0]   cache_rd_addr;
  logic [XLEN-1:0]   cache_rd_data;
  logic [XLEN-1:0]   cache_wr_addr;
  logic [XLEN-1:0]   cache_wr_data;
  logic [STRB_W-1:0] cache_wr_strb;

  // Cache to backing memory
  logic              mem_ren;
  logic              mem_rvalid;
  logic              mem_we;
  logic [XLEN-1:0]   mem_raddr;
  logic [XLEN-1:0]   mem_rdata;
  logic [XLEN-1:0]   mem_waddr;
  logic [XLEN-1:0]   mem_wdata;
  logic [STRB_W-1:0] mem_wstrb;

  // Bridge to scratch I/O RAM
  logic              io_ren;
  logic              io_wen;
  logic [XLEN-1:0]   io_raddr;
  logic [XLEN-1:0]   io_rdata;
  logic [XLEN-1:0]   io_waddr;
  logic [XLEN-1:0]   io_wdata;
  logic [STRB_W-1:0] io_wstrb;

  dmem_cache_bridge bridge_inst (.*);

  dcache dcache_inst (
    .clk, .rst_n,
    .rd_valid(cache_rd_valid), .rd_ready(cache_rd_ready), .rd_addr(cache_rd_addr),
    .rd_data(cache_rd_data), .rd_data_valid(cache_rd_data_valid),
    .wr_valid(cache_wr_valid), .wr_ready(cache_wr_ready), .wr_addr(cache_wr_addr),
    .wr_data(cache_wr_data), .wr_strb(cache_wr_strb),
    .mem_ren, .mem_raddr, .mem_rvalid, .mem_rdata,
    .mem_we, .mem_waddr, .mem_wdata, .mem_wstrb
  );

  backing_mem backing_mem_inst (
    .clk, .rst_n,
    .ren(mem_ren), .raddr(mem_raddr), .rvalid(mem_rvalid), .rdata(mem_rdata),
    .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata), .wstrb(mem_wstrb)
  );

  io_scratch_ram io_ram_inst (
    .clk,
    .ren(io_ren), .raddr(io_raddr), .rdata(io_rdata),
    .wen(io_wen), .waddr(io_waddr), .wdata(io_wdata), .wstrb(io_wstrb)
  );

endmodule

`default_nettype wire

// ==== verification/dmem_bridge_chk.sv ====
`default_nettype none

module dmem_bridge_chk (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            dmem_ren,
  input logic                            dmem_we,
  input logic                            dmem_stall,
  input logic                            completing,
  input logic                            cache_rd_valid,
  input logic                            cache_rd_ready,
  input logic [dmem_map_pkg::XLEN-1:0]   cache_rd_addr,
  input logic                            cache_wr_valid,
  input logic                            cache_wr_ready,
  input logic [dmem_map_pkg::XLEN-1:0]   cache_wr_addr,
  input logic [dmem_map_pkg::XLEN-1:0]   cache_wr_data,
  input logic [dmem_map_pkg::STRB_W-1:0] cache_wr_strb,
  input logic                            io_ren
);

  // Nothing in flight and no cooldown, so the core must run
  idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!cache_rd_valid && !cache_wr_valid && !completing && !dmem_ren && !dmem_we)
      |-> !dmem_stall)
    else $error("stall raised with no request and no cooldown pending");

  // Read address held while the cache pushes back
  rd_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (cache_rd_valid && !cache_rd_ready) |=> $stable(cache_rd_addr))
    else $error("cache read address changed under back-pressure");

  // Write request held complete until taken
  wr_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (cache_wr_valid && !cache_wr_ready)
      |=> (cache_wr_valid && $stable(cache_wr_addr) && $stable(cache_wr_data)
           && $stable(cache_wr_strb)))
    else $error("cache write request dropped or changed under back-pressure");

  // One cache channel at a time
  one_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(cache_rd_valid && cache_wr_valid))
    else $error("cache read and write valid high together");

  // I/O reads pass straight through
  io_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
    io_ren |-> !dmem_stall)
    else $error("stall raised during an I/O read");

endmodule

bind dmem_cache_bridge dmem_bridge_chk bridge_chk_inst (
  .clk(clk),
  .rst_n(rst_n),
  .dmem_ren(dmem_ren),
  .dmem_we(dmem_we),
  .dmem_stall(dmem_stall),
  .completing(completing),
  .cache_rd_valid(cache_rd_valid),
  .cache_rd_ready(cache_rd_ready),
  .cache_rd_addr(cache_rd_addr),
  .cache_wr_valid(cache_wr_valid),
  .cache_wr_ready(cache_wr_ready),
  .cache_wr_addr(cache_wr_addr),
  .cache_wr_data(cache_wr_data),
  .cache_wr_strb(cache_wr_strb),
  .io_ren(io_ren)
);

`default_nettype wire

// ==== verification/dmem_subsystem_tb.sv ====
`default_nettype none

module dmem_subsystem_tb;
  import dmem_map_pkg::*;
  import dcache_cfg_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  // Worst cached access is a miss, well inside this many cycles
  localparam int OP_CYCLES    = MEM_LATENCY + 8;
  // Upper bound on core operations over all tests
  localparam int OP_BOUND     = 300;

  logic              clk;
  logic              rst_n;
  logic              dmem_ren;
  logic [XLEN-1:0]   dmem_raddr;
  logic [XLEN-1:0]   dmem_rdata;
  logic              dmem_we;
  logic [XLEN-1:0]   dmem_waddr;
  logic [XLEN-1:0]   dmem_wdata;
  logic [STRB_W-1:0] dmem_wstrb;
  logic              dmem_stall;

  // Shadow copies, both memories start at zero
  logic [XLEN-1:0] main_shadow [MEM_WORDS] = '{default: '0};
  logic [XLEN-1:0] io_shadow [IO_WORDS] = '{default: '0};

  int     errors;
  int     checks;
  integer seed;

  dmem_subsystem dmem_subsystem_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Byte lanes with a set strobe take the new data
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_word,
                                                  input logic [XLEN-1:0] new_word,
                                                  input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Bit 31 picks the I/O RAM, low word bits index it
  function automatic logic [XLEN-1:0] shadow_read(input logic [XLEN-1:0] addr);
    if (addr[IO_SEL_BIT]) begin
      return io_shadow[addr[IO_AW+1:2]];
    end
    return main_shadow[addr[MEM_AW+1:2]];
  endfunction

  task automatic shadow_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                              input logic [STRB_W-1:0] strb);
    if (addr[IO_SEL_BIT]) begin
      io_shadow[addr[IO_AW+1:2]] = merge_bytes(io_shadow[addr[IO_AW+1:2]], data, strb);
    end else begin
      main_shadow[addr[MEM_AW+1:2]] = merge_bytes(main_shadow[addr[MEM_AW+1:2]], data, strb);
    end
  endtask

  // One core load or store, held while stalled, dropped once stall is low
  task automatic core_access(input bit is_load, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] data, input logic [STRB_W-1:0] strb);
    int              stall_cycles;
    bit              is_io;
    bit              cooldown;
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] expected;
    is_io = addr[IO_SEL_BIT];
    expected = shadow_read(addr);
    stall_cycles = 0;
    @(posedge clk);
    if (is_load) begin
      dmem_ren   <= 1'b1;
      dmem_raddr <= addr;
    end else begin
      dmem_we    <= 1'b1;
      dmem_waddr <= addr;
      dmem_wdata <= data;
      dmem_wstrb <= strb;
    end
    @(negedge clk);
    while (dmem_stall && stall_cycles < OP_CYCLES) begin
      stall_cycles++;
      @(negedge clk);
    end
    assert (!dmem_stall) else begin
      errors++;
      $display("Access to %h at %0t still stalled after %0d cycles", addr, $time, OP_CYCLES);
    end
    // Cached word is valid in the first cycle with stall low
    got = dmem_rdata;
    @(posedge clk);
    dmem_ren <= 1'b0;
    dmem_we  <= 1'b0;
    @(negedge clk);
    cooldown = dmem_stall;
    // I/O word shows up the cycle after the request
    if (is_io) begin
      got = dmem_rdata;
    end
    checks++;
    if (is_io) begin
      assert (stall_cycles == 0 && !cooldown) else begin
        errors++;
        $display("ERR @%0t: I/O access to %h raised stall", $time, addr);
      end
    end else begin
      assert (stall_cycles >= 1 && cooldown) else begin
        errors++;
        $display("ERR @%0t: access to %h stalled %0d cycles, cooldown %0b",
                 $time, addr, stall_cycles, cooldown);
      end
    end
    if (is_load) begin
      checks++;
      assert (got === expected) else begin
        errors++;
        $display("ERR @%0t: load %h returned %h, expected %h", $time, addr, got, expected);
      end
    end else begin
      shadow_write(addr, data, strb);
    end
  endtask

  task automatic load_word(input logic [XLEN-1:0] addr);
    core_access(1'b1, addr, '0, '0);
  endtask

  task automatic store_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                            input logic [STRB_W-1:0] strb);
    core_access(1'b0, addr, data, strb);
  endtask

  // Write-through then miss and fill
  task automatic store_then_load();
    store_word(32'h0000_0100, 32'hCAFE_F00D, 4'b1111);
    load_word(32'h0000_0100);
  endtask

  // Byte merges on a resident line, then on a line never loaded
  task automatic partial_stores();
    load_word(32'h0000_0200);
    store_word(32'h0000_0200, 32'h1122_3344, 4'b1111);
    store_word(32'h0000_0200, 32'hAABB_CCDD, 4'b0101);
    store_word(32'h0000_0200, 32'h5566_7788, 4'b1000);
    load_word(32'h0000_0200);
    store_word(32'h0000_0304, 32'h0102_0304, 4'b0011);
    store_word(32'h0000_0304, 32'hF1F2_F3F4, 4'b1100);
    store_word(32'h0000_0304, 32'h9999_9999, 4'b0110);
    load_word(32'h0000_0304);
  endtask

  // Same low bits in cache and I/O RAM hold different words
  task automatic io_bypass();
    store_word(32'h0000_0040, 32'hA5A5_0001, 4'b1111);
    load_word(32'h0000_0040);
    store_word(32'h8000_0040, 32'h5A5A_0002, 4'b1111);
    load_word(32'h8000_0040);
    store_word(32'h8000_0044, 32'h0000_BEEF, 4'b0011);
    load_word(32'h8000_0044);
    load_word(32'h0000_0040);
  endtask

  // Line index 4 with tags 0 and 1, evicted back and forth
  task automatic index_conflict();
    store_word(32'h0000_0010, 32'h1111_AAAA, 4'b1111);
    load_word(32'h0000_0010);
    load_word(32'h0000_0050);
    store_word(32'h0000_0050, 32'h2222_BBBB, 4'b1111);
    load_word(32'h0000_0010);
    load_word(32'h0000_0050);
    store_word(32'h0000_0010, 32'h0033_0000, 4'b0100);
    load_word(32'h0000_0050);
    load_word(32'h0000_0010);
  endtask

  // Loaded word stays on dmem_rdata while the core idles
  task automatic hold_after_load();
    logic [XLEN-1:0] expected;
    store_word(32'h0000_00A8, 32'h5A5A_0F0F, 4'b1111);
    load_word(32'h0000_00A8);
    load_word(32'h0000_00A8);
    expected = shadow_read(32'h0000_00A8);
    repeat (6) begin
      @(negedge clk);
      checks++;
      assert (dmem_rdata === expected) else begin
        errors++;
        $display("ERR @%0t: idle rdata %h, expected %h", $time, dmem_rdata, expected);
      end
    end
  endtask

  // Mixed loads and stores, a quarter of them to I/O
  task automatic random_mix(input int count);
    logic [31:0]       r;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      data = $random(seed);
      strb = r[6:3];
      // 64 words over 16 lines gives plenty of conflicts
      if (r[1:0] == 2'b00) begin
        addr = {1'b1, 23'h0, r[13:8], 2'b00};
      end else begin
        addr = {24'h0, r[13:8], 2'b00};
      end
      core_access(r[2], addr, data, strb);
    end
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    seed       = 7128;
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_we    = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    store_then_load();
    partial_stores();
    io_bypass();
    index_conflict();
    hold_after_load();
    random_mix(200);
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the operation bound
  initial begin
    #((RESET_CYCLES + OP_BOUND * OP_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/dmem_map_pkg.sv
source/dcache_cfg_pkg.sv
source/backing_mem.sv
source/io_scratch_ram.sv
source/dcache.sv
source/dmem_cache_bridge.sv
source/dmem_subsystem.sv
verification/dmem_bridge_chk.sv
verification/dmem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: dmem_subsystem

sources:
  - source/dmem_map_pkg.sv
  - source/dcache_cfg_pkg.sv
  - source/backing_mem.sv
  - source/io_scratch_ram.sv
  - source/dcache.sv
  - source/dmem_cache_bridge.sv
  - source/dmem_subsystem.sv
  - target: simulation
    files:
      - verification/dmem_bridge_chk.sv
      - verification/dmem_subsystem_tb.sv
